// ==== all.f ====
logic/icache_pkg.sv
logic/icache_tag_store.sv
logic/icache_miss_fsm.sv
logic/icache_sram_port.sv
logic/icache_fetch_out.sv
logic/icache_top.sv
tests/icache_mem_model.sv
tests/icache_tb.sv

// ==== tests/icache_tb.sv ====
`timescale 1ns/10ps

module icache_tb import icache_pkg::*; ();

    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [inst_w-1:0] exp_word;
        int                stall_cycles;
        bit                flush_mid;
        bit                exp_error;
        int                exp_xfers;
    } fetch_entry_t;

    logic                            clk;
    logic                            rst;
    logic [addr_w-1:0]               pc;
    logic                            flush;
    logic                            stall;
    logic                            arready;
    axi_r_t                          axi_r;
    logic [num_banks-1:0][row_w-1:0] sram_rdata;
    axi_ar_t                         axi_ar;
    logic                            rready;
    sram_req_t [num_banks-1:0]       sram_req;
    logic [inst_w-1:0]               inst;
    logic                            inst_valid;
    logic                            inst_error;

    fetch_entry_t      stim_table [$];
    int                errors = 0;
    int                passed = 0;
    int                xfer_count = 0;

    // tag predictor
    bit                pred_valid  [num_ways][2**index_w];
    logic [tag_w-1:0]  pred_tag    [num_ways][2**index_w];
    bit                pred_toggle [2**index_w];

    icache_top icache_top_inst (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .flush      (flush),
        .stall      (stall),
        .arready    (arready),
        .axi_r      (axi_r),
        .sram_rdata (sram_rdata),
        .axi_ar     (axi_ar),
        .rready     (rready),
        .sram_req   (sram_req),
        .inst       (inst),
        .inst_valid (inst_valid),
        .inst_error (inst_error)
    );

    icache_mem_model icache_mem_model_inst (
        .clk        (clk),
        .rst        (rst),
        .axi_ar     (axi_ar),
        .rready     (rready),
        .sram_req   (sram_req),
        .arready    (arready),
        .axi_r      (axi_r),
        .sram_rdata (sram_rdata)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] expected_word(input logic [addr_w-1:0] a);
        return {a[addr_w-1:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // block-aligned address of the missing pc, one 8-byte beat
    always @(negedge clk) begin
        if (!rst && axi_ar.arvalid && arready) begin
            xfer_count <= xfer_count + 1;
            check_value("araddr", axi_ar.araddr, pc & 32'hffff_fff8);
            check_value("arsize", axi_ar.arsize, 3'd3);
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic add_entry(input logic [addr_w-1:0] a, input int stall_n,
                             input bit fl, input bit err, input int xfers);
        stim_table.push_back('{pc: a, exp_word: expected_word(a), stall_cycles: stall_n,
                               flush_mid: fl, exp_error: err, exp_xfers: xfers});
    endtask

    // miss on no matching valid way, fill only on a good response
    task automatic predict_xfers(input logic [addr_w-1:0] a, input bit is_error,
                                 output int n);
        logic [index_w-1:0] idx;
        logic [tag_w-1:0]   tg;
        int                 way;
        idx = a[offset_w +: index_w];
        tg  = a[addr_w-1 -: tag_w];
        n   = 1;
        for (int w = 0; w < num_ways; w++) begin
            if (pred_valid[w][idx] && pred_tag[w][idx] == tg) begin
                n = 0;
            end
        end
        if (n == 1 && !is_error) begin
            if (!pred_valid[0][idx]) begin
                way = 0;
            end else if (!pred_valid[1][idx]) begin
                way = 1;
            end else begin
                way = pred_toggle[idx];
                pred_toggle[idx] = !pred_toggle[idx];
            end
            pred_valid[way][idx] = 1'b1;
            pred_tag[way][idx]   = tg;
        end
    endtask

    task automatic wait_for_result(output bit seen);
        seen = 1'b0;
        for (int i = 0; i < 200 && !seen; i++) begin
            @(negedge clk);
            seen = inst_valid;
        end
    endtask

    task automatic wait_for_handshake(output bit seen);
        seen = 1'b0;
        for (int i = 0; i < 200 && !seen; i++) begin
            @(negedge clk);
            seen = axi_ar.arvalid && arready;
        end
    endtask

    task automatic wait_refill_end(output bit seen);
        seen = 1'b0;
        for (int i = 0; i < 200 && !seen; i++) begin
            @(negedge clk);
            check_value("inst_valid", inst_valid, 1'b0);
            seen = !rready;
        end
    endtask

    // cancel the duplicate lookup result, then park under stall
    task automatic drain_pipeline();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        stall <= 1'b1;
    endtask

    task automatic run_entry(input fetch_entry_t e);
        int                xfers_before;
        int                pred;
        bit                seen;
        logic [inst_w-1:0] held;
        xfers_before = xfer_count;
        predict_xfers(e.pc, e.exp_error, pred);
        @(posedge clk);
        pc    <= e.pc;
        stall <= 1'b0;
        flush <= 1'b0;
        if (e.flush_mid) begin
            wait_for_handshake(seen);
            if (!seen) report_failure("timeout waiting for the read address transfer");
            @(posedge clk);
            flush <= 1'b1;
            @(posedge clk);
            flush <= 1'b0;
            stall <= 1'b1;
            wait_refill_end(seen);
            if (!seen) report_failure("timeout waiting for the discarded refill to end");
            repeat (4) begin
                @(negedge clk);
                check_value("inst_valid", inst_valid, 1'b0);
            end
        end else begin
            wait_for_result(seen);
            if (!seen) begin
                report_failure("timeout waiting for inst_valid");
            end else begin
                check_value("inst", inst, e.exp_word);
                check_value("inst_error", inst_error, e.exp_error);
                held = inst;
                if (e.stall_cycles > 0) begin
                    @(posedge clk);
                    stall <= 1'b1;
                    repeat (e.stall_cycles) begin
                        @(negedge clk);
                        check_value("inst_valid", inst_valid, 1'b1);
                        check_value("inst", inst, held);
                    end
                    @(posedge clk);
                    stall <= 1'b0;
                    @(negedge clk);
                    check_value("inst_valid", inst_valid, 1'b1);
                    check_value("inst", inst, held);
                end
            end
            drain_pipeline();
        end
        check_value("address transfers", xfer_count - xfers_before, e.exp_xfers);
        check_value("predicted transfers", xfer_count - xfers_before, pred);
    endtask

    // ==================================================
    // stimulus
    // ==================================================
    initial begin
        int errors_before;
        void'($urandom(32'hc96d));
        rst   = 1'b1;
        pc    = '0;
        flush = 1'b0;
        stall = 1'b1;

        // set 0 holds 0x1000, 0x2000 and 0x3000
        add_entry(32'h0000_1000, 0, 1'b0, 1'b0, 1);
        add_entry(32'h0000_1000, 0, 1'b0, 1'b0, 0);
        add_entry(32'h0000_1004, 0, 1'b0, 1'b0, 0);
        add_entry(32'h0000_2000, 0, 1'b0, 1'b0, 1);
        add_entry(32'h0000_3000, 0, 1'b0, 1'b0, 1);
        add_entry(32'h0000_2000, 0, 1'b0, 1'b0, 0);
        add_entry(32'h0000_1000, 0, 1'b0, 1'b0, 1);
        add_entry(32'h0000_3000, 0, 1'b0, 1'b0, 0);
        add_entry(32'h0000_2000, 0, 1'b0, 1'b0, 1);
        add_entry(32'h0000_4008, 0, 1'b1, 1'b0, 1);
        add_entry(32'h0000_5010, 0, 1'b0, 1'b0, 1);
        add_entry(32'h0000_4008, 0, 1'b0, 1'b0, 0);
        add_entry(32'h0000_4008, 5, 1'b0, 1'b0, 0);
        add_entry(32'h0000_6000, 3, 1'b0, 1'b0, 1);
        add_entry(32'hf000_0100, 0, 1'b0, 1'b1, 1);
        add_entry(32'hf000_0100, 0, 1'b0, 1'b1, 1);

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        foreach (stim_table[i]) begin
            errors_before = errors;
            run_entry(stim_table[i]);
            if (errors == errors_before) begin
                passed++;
                $display("test %0d pc 0x%h ok", i, stim_table[i].pc);
            end else begin
                $display("test %0d pc 0x%h failed", i, stim_table[i].pc);
            end
        end

        $display("tests %0d, passed %0d, errors %0d", stim_table.size(), passed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/icache_mem_model.sv ====
`timescale 1ns/10ps

module icache_mem_model import icache_pkg::*; (
    input  logic                            clk,
    input  logic                            rst,
    input  axi_ar_t                         axi_ar,
    input  logic                            rready,
    input  sram_req_t [num_banks-1:0]       sram_req,
    output logic                            arready,
    output axi_r_t                          axi_r,
    output logic [num_banks-1:0][row_w-1:0] sram_rdata
);

    logic [row_w-1:0]  bank_mem [num_banks][2**bank_addr_w];
    logic [addr_w-1:0] beat_addr;
    logic              beat_pending;
    int                ar_wait;
    int                r_wait;

    function automatic logic [31:0] word_at(input logic [addr_w-1:0] a);
        return {a[addr_w-1:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    // ==================================================
    // SRAM banks
    // ==================================================
    initial begin
        for (int b = 0; b < num_banks; b++) begin
            for (int r = 0; r < 2**bank_addr_w; r++) begin
                bank_mem[b][r] = {4{32'(b * 64 + r) ^ 32'hc0de0000}};
            end
        end
    end

    // cleared mask bits take the write data
    always @(posedge clk) begin
        for (int b = 0; b < num_banks; b++) begin
            if (!sram_req[b].cen) begin
                if (!sram_req[b].wen) begin
                    bank_mem[b][sram_req[b].addr] <=
                        (bank_mem[b][sram_req[b].addr] & sram_req[b].wmask) |
                        (sram_req[b].wdata & ~sram_req[b].wmask);
                end else begin
                    sram_rdata[b] <= bank_mem[b][sram_req[b].addr];
                end
            end
        end
    end

    // ==================================================
    // AXI read slave, one beat per address
    // ==================================================
    always @(posedge clk) begin
        if (rst) begin
            arready      <= 1'b0;
            axi_r        <= '0;
            beat_addr    <= '0;
            beat_pending <= 1'b0;
            ar_wait      <= $urandom % 6;
            r_wait       <= 0;
        end else begin
            if (axi_ar.arvalid && arready) begin
                arready      <= 1'b0;
                beat_addr    <= axi_ar.araddr;
                beat_pending <= 1'b1;
                r_wait       <= $urandom % 6;
                ar_wait      <= $urandom % 6;
            end else if (!axi_ar.arvalid) begin
                arready <= 1'b0;
            end else if (!beat_pending && !axi_r.rvalid) begin
                if (ar_wait == 0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 1;
                end
            end

            if (beat_pending) begin
                if (r_wait == 0) begin
                    beat_pending <= 1'b0;
                    axi_r.rvalid <= 1'b1;
                    axi_r.rlast  <= 1'b1;
                    axi_r.rdata  <= {word_at(beat_addr + 4), word_at(beat_addr)};
                    // top nibble all ones is the error region
                    axi_r.rresp  <= (beat_addr[addr_w-1 -: 4] == 4'hf) ? 2'b10 : resp_okay;
                end else begin
                    r_wait <= r_wait - 1;
                end
            end else if (axi_r.rvalid && rready) begin
                axi_r <= '0;
            end
        end
    end

endmodule

// ==== logic/icache_top.sv ====
`timescale 1ns/10ps

module icache_top import icache_pkg::*; (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [addr_w-1:0]               pc,
    input  logic                            flush,
    input  logic                            stall,
    input  logic                            arready,
    input  axi_r_t                          axi_r,
    input  logic [num_banks-1:0][row_w-1:0] sram_rdata,
    output axi_ar_t                         axi_ar,
    output logic                            rready,
    output sram_req_t [num_banks-1:0]       sram_req,
    output logic [inst_w-1:0]               inst,
    output logic                            inst_valid,
    output logic                            inst_error
);

    logic              lookup;
    logic              hit;
    logic              hit_way;
    logic              victim_way;
    logic              fill;
    logic [addr_w-1:0] fill_addr;
    logic              beat_done;
    logic              beat_error;
    logic              beat_discard;
    logic [inst_w-1:0] hit_word;

    icache_tag_store icache_tag_store_inst (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (pc),
        .fill        (fill),
        .fill_addr   (fill_addr),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way)
    );

    icache_miss_fsm icache_miss_fsm_inst (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .stall        (stall),
        .flush        (flush),
        .hit          (hit),
        .arready      (arready),
        .axi_r        (axi_r),
        .state        (),
        .lookup       (lookup),
        .axi_ar       (axi_ar),
        .rready       (rready),
        .fill         (fill),
        .fill_addr    (fill_addr),
        .beat_done    (beat_done),
        .beat_error   (beat_error),
        .beat_discard (beat_discard)
    );

    icache_sram_port icache_sram_port_inst (
        .clk         (clk),
        .rst         (rst),
        .lookup      (lookup),
        .lookup_addr (pc),
        .hit_way     (hit_way),
        .fill        (fill),
        .fill_addr   (fill_addr),
        .victim_way  (victim_way),
        .axi_r       (axi_r),
        .sram_rdata  (sram_rdata),
        .sram_req    (sram_req),
        .hit_word    (hit_word)
    );

    icache_fetch_out icache_fetch_out_inst (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .flush        (flush),
        .lookup       (lookup),
        .hit          (hit),
        .hit_word     (hit_word),
        .beat_done    (beat_done),
        .beat_error   (beat_error),
        .beat_discard (beat_discard),
        .fill_addr    (fill_addr),
        .axi_r        (axi_r),
        .inst         (inst),
        .inst_valid   (inst_valid),
        .inst_error   (inst_error)
    );

endmodule

// ==== logic/icache_fetch_out.sv ====
`timescale 1ns/10ps

module icache_fetch_out import icache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic              flush,
    input  logic              lookup,
    input  logic              hit,
    input  logic [inst_w-1:0] hit_word,
    input  logic              beat_done,
    input  logic              beat_error,
    input  logic              beat_discard,
    input  logic [addr_w-1:0] fill_addr,
    input  axi_r_t            axi_r,
    output logic [inst_w-1:0] inst,
    output logic              inst_valid,
    output logic              inst_error
);

    logic [inst_w-1:0] inst_q;
    logic              fresh_q;
    logic              hit_take;
    logic              beat_take;
    logic [inst_w-1:0] refill_word;

    assign hit_take    = lookup && hit;
    assign beat_take   = beat_done && !beat_discard;
    assign refill_word = fill_addr[offset_w-1] ? axi_r.rdata[beat_w-1 -: inst_w]
                                               : axi_r.rdata[inst_w-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_valid <= 1'b0;
            inst_error <= 1'b0;
            fresh_q    <= 1'b0;
            inst_q     <= nop_inst;
        end else begin
            // hit word only lives for one cycle on the SRAM port
            if (fresh_q) begin
                inst_q <= hit_word;
            end
            fresh_q <= 1'b0;
            if (inst_valid && stall) begin
                inst_valid <= 1'b1;
            end else if (flush && !stall) begin
                inst_valid <= 1'b0;
                inst_error <= 1'b0;
                inst_q     <= nop_inst;
            end else begin
                inst_valid <= hit_take || beat_take;
                inst_error <= beat_take && beat_error;
                fresh_q    <= hit_take;
                if (beat_take) begin
                    inst_q <= refill_word;
                end
            end
        end
    end

    assign inst = fresh_q ? hit_word : inst_q;

endmodule

// ==== logic/icache_sram_port.sv ====
`timescale 1ns/10ps

module icache_sram_port import icache_pkg::*; (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              lookup,
    input  logic [addr_w-1:0]                 lookup_addr,
    input  logic                              hit_way,
    input  logic                              fill,
    input  logic [addr_w-1:0]                 fill_addr,
    input  logic                              victim_way,
    input  axi_r_t                            axi_r,
    input  logic [num_banks-1:0][row_w-1:0]   sram_rdata,
    output sram_req_t [num_banks-1:0]         sram_req,
    output logic [inst_w-1:0]                 hit_word
);

    logic [addr_w-1:0]      req_addr;
    logic [bank_sel_w-1:0]  req_bank;
    logic [bank_addr_w-1:0] req_row;
    logic [row_w-1:0]       fill_mask;

    logic [bank_sel_w-1:0]  rd_bank_q;
    logic                   rd_way_q;
    logic                   rd_word_q;
    logic [row_w-1:0]       rd_row;
    logic [beat_w-1:0]      rd_half;

    // fill and lookup never share a cycle
    assign req_addr = fill ? fill_addr : lookup_addr;
    assign req_row  = req_addr[offset_w +: bank_addr_w];
    assign req_bank = req_addr[offset_w + bank_addr_w +: bank_sel_w];

    // way 1 owns the upper half of a row, cleared mask bits are written
    assign fill_mask = victim_way ? {{beat_w{1'b0}}, {beat_w{1'b1}}}
                                  : {{beat_w{1'b1}}, {beat_w{1'b0}}};

    // ==================================================
    // bank requests
    // ==================================================
    always_comb begin
        for (int b = 0; b < num_banks; b++) begin
            sram_req[b].cen   = !((lookup || fill) && (req_bank == bank_sel_w'(b)));
            sram_req[b].wen   = !(fill && (req_bank == bank_sel_w'(b)));
            sram_req[b].addr  = req_row;
            sram_req[b].wmask = fill_mask;
            sram_req[b].wdata = {axi_r.rdata, axi_r.rdata};
        end
    end

    // ==================================================
    // read select, one cycle after the lookup
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_bank_q <= '0;
            rd_way_q  <= 1'b0;
            rd_word_q <= 1'b0;
        end else if (lookup) begin
            rd_bank_q <= req_bank;
            rd_way_q  <= hit_way;
            rd_word_q <= lookup_addr[offset_w-1];
        end
    end

    assign rd_row  = sram_rdata[rd_bank_q];
    assign rd_half = rd_way_q ? rd_row[row_w-1 -: beat_w] : rd_row[beat_w-1:0];

    assign hit_word = rd_word_q ? rd_half[beat_w-1 -: inst_w] : rd_half[inst_w-1:0];

endmodule

// ==== logic/icache_miss_fsm.sv ====
`timescale 1ns/10ps

module icache_miss_fsm import icache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [addr_w-1:0] pc,
    input  logic              stall,
    input  logic              flush,
    input  logic              hit,
    input  logic              arready,
    input  axi_r_t            axi_r,
    output fetch_state_e      state,
    output logic              lookup,
    output axi_ar_t           axi_ar,
    output logic              rready,
    output logic              fill,
    output logic [addr_w-1:0] fill_addr,
    output logic              beat_done,
    output logic              beat_error,
    output logic              beat_discard
);

    logic              arvalid_q;
    logic [addr_w-1:0] araddr_q;
    logic              discard_q;

    logic              flush_now;
    logic              miss_start;
    logic              ar_done;
    logic              beat;
    logic              resp_ok;

    // flush under stall is ignored
    assign flush_now  = flush && !stall;
    assign lookup     = (state == state_lookup) && !stall;
    assign miss_start = lookup && !hit && !flush;
    assign ar_done    = (state == state_request) && arvalid_q && arready;
    assign beat       = (state == state_wait) && rready && axi_r.rvalid;
    assign resp_ok    = (axi_r.rresp == resp_okay);

    // ==================================================
    // lookup / request / wait
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= state_lookup;
            arvalid_q <= 1'b0;
            rready    <= 1'b0;
            discard_q <= 1'b0;
        end else begin
            case (state)
                state_lookup: begin
                    if (miss_start) begin
                        state     <= state_request;
                        arvalid_q <= 1'b1;
                    end
                end
                state_request: begin
                    // address already taken, so the beat must still be drained
                    if (ar_done) begin
                        state     <= state_wait;
                        arvalid_q <= 1'b0;
                        rready    <= 1'b1;
                        discard_q <= flush_now;
                    end else if (flush_now) begin
                        state     <= state_lookup;
                        arvalid_q <= 1'b0;
                    end
                end
                state_wait: begin
                    if (beat) begin
                        state     <= state_lookup;
                        rready    <= 1'b0;
                        discard_q <= 1'b0;
                    end else if (flush_now) begin
                        discard_q <= 1'b1;
                    end
                end
                default: begin
                    state     <= state_lookup;
                    arvalid_q <= 1'b0;
                    rready    <= 1'b0;
                    discard_q <= 1'b0;
                end
            endcase
        end
    end

    // missing pc, held for the fill and the refill word select
    always_ff @(posedge clk) begin
        if (miss_start) begin
            araddr_q  <= {pc[addr_w-1:offset_w], {offset_w{1'b0}}};
            fill_addr <= pc;
        end
    end

    assign axi_ar = '{arvalid: arvalid_q, araddr: araddr_q, arsize: arsize_beat};

    // beat strobes
    assign fill         = beat && resp_ok;
    assign beat_done    = beat;
    assign beat_error   = beat && !resp_ok;
    assign beat_discard = discard_q || flush_now;

endmodule

// ==== logic/icache_tag_store.sv ====
`timescale 1ns/10ps

module icache_tag_store import icache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [addr_w-1:0] lookup_addr,
    input  logic              fill,
    input  logic [addr_w-1:0] fill_addr,
    output logic              hit,
    output logic              hit_way,
    output logic              victim_way
);

    logic [tag_w-1:0]      tag_mem [num_ways][2**index_w];
    logic [2**index_w-1:0] valid_q [num_ways];
    logic [2**index_w-1:0] toggle_q;

    logic [index_w-1:0]    lk_index;
    logic [tag_w-1:0]      lk_tag;
    logic [index_w-1:0]    fl_index;
    logic [tag_w-1:0]      fl_tag;
    logic [num_ways-1:0]   way_match;
    logic                  both_valid;

    assign lk_index = lookup_addr[offset_w +: index_w];
    assign lk_tag   = lookup_addr[addr_w-1 -: tag_w];
    assign fl_index = fill_addr[offset_w +: index_w];
    assign fl_tag   = fill_addr[addr_w-1 -: tag_w];

    // ==================================================
    // hit compare on both ways of the set
    // ==================================================
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_match[w] = valid_q[w][lk_index] && (tag_mem[w][lk_index] == lk_tag);
        end
    end

    assign hit     = |way_match;
    assign hit_way = way_match[1];

    // first invalid way, else the set toggle
    assign both_valid = valid_q[0][fl_index] && valid_q[1][fl_index];

    always_comb begin
        if (!valid_q[0][fl_index]) begin
            victim_way = 1'b0;
        end else if (!valid_q[1][fl_index]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = toggle_q[fl_index];
        end
    end

    // ==================================================
    // fill update
    // ==================================================
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[victim_way][fl_index] <= fl_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < num_ways; w++) begin
                valid_q[w] <= '0;
            end
            toggle_q <= '0;
        end else if (fill) begin
            valid_q[victim_way][fl_index] <= 1'b1;
            // only a real eviction moves the toggle
            if (both_valid) begin
                toggle_q[fl_index] <= ~toggle_q[fl_index];
            end
        end
    end

endmodule

// ==== logic/icache_pkg.sv ====
package icache_pkg;

    // ==================================================
    // fetch address fields
    // ==================================================
    localparam int addr_w      = 32;
    localparam int inst_w      = 32;
    localparam int offset_w    = 3;
    localparam int index_w     = 8;
    localparam int tag_w       = 21;

    // upper index bits pick the bank, lower bits the row
    localparam int bank_sel_w  = 2;
    localparam int bank_addr_w = 6;

    // ==================================================
    // cache geometry
    // ==================================================
    localparam int num_banks   = 4;
    localparam int num_ways    = 2;
    localparam int row_w       = 128;
    localparam int beat_w      = 64;

    // AXI read response and transfer size
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [2:0] arsize_beat = 3'b011;

    // addi x0, x0, 0
    localparam logic [inst_w-1:0] nop_inst = 32'h0000_0013;

    typedef enum logic [1:0] {
        state_lookup  = 2'd0,
        state_request = 2'd1,
        state_wait    = 2'd2
    } fetch_state_e;

    // one SRAM bank request, cen/wen/wmask all active low
    typedef struct packed {
        logic                   cen;
        logic                   wen;
        logic [bank_addr_w-1:0] addr;
        logic [row_w-1:0]       wmask;
        logic [row_w-1:0]       wdata;
    } sram_req_t;

    typedef struct packed {
        logic              arvalid;
        logic [addr_w-1:0] araddr;
        logic [2:0]        arsize;
    } axi_ar_t;

    typedef struct packed {
        logic              rvalid;
        logic [1:0]        rresp;
        logic [beat_w-1:0] rdata;
        logic              rlast;
    } axi_r_t;

endpackage
